/* all.f */
hw/bfbrk_pkg.sv
hw/bfbrk_slot_bank.sv
hw/bfbrk_host_regs.sv
hw/bfbrk_match.sv
hw/bfbrk_top.sv
verification/bfbrk_sva.sv
verification/tb_bfbrk.sv

/* hw/bfbrk_host_regs.sv */
// Host writes are single-cycle strobes; only word-aligned offsets decode, others read zero

`timescale 1ns/1ps

module bfbrk_host_regs #(
	parameter int N_SLOTS = bfbrk_pkg::SLOT_MAX
) (
	input  logic                   BASECK,
	input  logic                   SYSRSOUTB,
	input  bfbrk_pkg::host_req_t   host,
	input  bfbrk_pkg::fetch_addr_t addr_entries [N_SLOTS],
	input  bfbrk_pkg::patch_word_t data_entries [N_SLOTS],
	output logic                   addr_wr_en,
	output logic                   data_wr_en,
	output bfbrk_pkg::slot_idx_t   wr_idx,
	output bfbrk_pkg::fetch_addr_t addr_wr_value,
	output bfbrk_pkg::patch_word_t data_wr_value,
	output logic [N_SLOTS-1:0]     enables,
	output bfbrk_pkg::host_word_t  rdata
);

	import bfbrk_pkg::*;

	logic [7:0] ofs;
	logic       unit_cs;       // Upper address bits hit this unit
	logic       word_aligned;
	logic       idx_ok;        // Slot number exists in this build
	logic       addr_cs;
	logic       data_cs;
	logic       ctrl_cs;

	// --------------------
	// Address decode
	// --------------------
	assign ofs          = host.addr[7:0];
	assign unit_cs      = (host.addr[31:8] == HOST_BASE);
	assign word_aligned = (ofs[1:0] == 2'b00);
	assign wr_idx       = ofs[4:2];
	assign idx_ok       = (int'(wr_idx) < N_SLOTS);

	assign addr_cs = unit_cs && word_aligned && idx_ok && (ofs[7:5] == ADDR_OFS[7:5]);
	assign data_cs = unit_cs && word_aligned && idx_ok && (ofs[7:5] == DATA_OFS[7:5]);
	assign ctrl_cs = unit_cs && (ofs == CTRL_OFS);

	// Write side towards the two banks
	assign addr_wr_en    = host.wr && addr_cs;
	assign data_wr_en    = host.wr && data_cs;
	assign addr_wr_value = host.wdata[19:2];   // Byte lanes and upper bits dropped
	assign data_wr_value = host.wdata;

	// --------------------
	// Enable register
	// --------------------
	always_ff @(posedge BASECK or negedge SYSRSOUTB) begin
		if (!SYSRSOUTB) begin
			enables <= '0;
		end else if (host.wr && ctrl_cs) begin
			enables <= host.wdata[N_SLOTS-1:0];
		end
	end

	// --------------------
	// Read-back
	// --------------------
	always_comb begin
		rdata = '0;
		if (addr_cs) begin
			rdata[19:2] = addr_entries[wr_idx];   // Back in byte address form
		end else if (data_cs) begin
			rdata = data_entries[wr_idx];
		end else if (ctrl_cs) begin
			rdata[N_SLOTS-1:0] = enables;         // Missing slots read as zero
		end
	end

endmodule

/* hw/bfbrk_match.sv */
// One patch result per BASECK; slot 0 has the highest priority when addresses overlap

`timescale 1ns/1ps

module bfbrk_match #(
	parameter int N_SLOTS = bfbrk_pkg::SLOT_MAX
) (
	input  logic                   BASECK,
	input  logic                   SYSRSOUTB,
	input  bfbrk_pkg::fetch_t      fetch,
	input  bfbrk_pkg::fetch_addr_t addr_entries [N_SLOTS],
	input  bfbrk_pkg::patch_word_t data_entries [N_SLOTS],
	input  logic [N_SLOTS-1:0]     enables,
	output bfbrk_pkg::patch_t      patch
);

	import bfbrk_pkg::*;

	logic [N_SLOTS-1:0] hit;        // Enabled slots equal to the fetch address
	logic               any_hit;
	logic               suppress;
	patch_word_t        hit_data;

	// --------------------
	// Compare and mask
	// --------------------
	always_comb begin
		for (int i = 0; i < N_SLOTS; i++) begin
			hit[i] = enables[i] && (addr_entries[i] == fetch.pa);
		end
	end

	assign any_hit = |hit;

	// Walk from the top so the lowest matching slot is the last one written
	always_comb begin
		hit_data = '0;
		for (int i = N_SLOTS - 1; i >= 0; i--) begin
			if (hit[i]) begin
				hit_data = data_entries[i];
			end
		end
	end

	// No patch in supervisor fetches or in the address phase of a waited read
	assign suppress = fetch.svmodf || (fetch.flread && fetch.pcwaitf);

	// --------------------
	// Patch outputs
	// --------------------
	always_ff @(posedge BASECK or negedge SYSRSOUTB) begin
		if (!SYSRSOUTB) begin
			patch.sel  <= 1'b0;
			patch.data <= '0;
		end else begin
			patch.sel  <= any_hit && !suppress;
			patch.data <= hit_data;    // Loaded even when sel is held low
		end
	end

endmodule

/* hw/bfbrk_pkg.sv */
// Host map fixed at 0x084030xx; at most 8 slots; flash fetch addresses are word addresses only

package bfbrk_pkg;

	// --------------------
	// Address map
	// --------------------
	localparam int SLOT_MAX = 8;                 // Largest slot count the map can hold

	localparam logic [23:0] HOST_BASE = 24'h084030;   // Upper host address bits of this unit

	localparam logic [7:0] ADDR_OFS = 8'h00;     // Address slots, stride 4
	localparam logic [7:0] DATA_OFS = 8'h20;     // Data slots, stride 4
	localparam logic [7:0] CTRL_OFS = 8'h40;     // Enable register

	// --------------------
	// Widths and words
	// --------------------
	typedef logic [31:0] host_word_t;
	typedef logic [17:0] fetch_addr_t;           // Byte address bits 19 to 2
	typedef logic [31:0] patch_word_t;
	typedef logic [2:0]  slot_idx_t;

	// Unused slots point at the top word of flash
	localparam fetch_addr_t ADDR_RESET = '1;

	// --------------------
	// Bus bundles
	// --------------------
	typedef struct packed {
		logic       wr;                          // Write strobe, sampled on BASECK
		host_word_t addr;
		host_word_t wdata;
	} host_req_t;

	typedef struct packed {
		fetch_addr_t pa;                         // Flash word address of the fetch
		logic        flread;
		logic        pcwaitf;
		logic        svmodf;                     // Supervisor mode fetch
	} fetch_t;

	typedef struct packed {
		logic        sel;                        // Memory block takes data in place of flash
		patch_word_t data;
	} patch_t;

endpackage

/* hw/bfbrk_slot_bank.sv */
// Entries load only through wr_en; the caller must keep wr_idx below N_SLOTS

`timescale 1ns/1ps

module bfbrk_slot_bank #(
	parameter int N_SLOTS = bfbrk_pkg::SLOT_MAX,
	parameter type payload_t = logic [31:0],
	parameter payload_t RESET_VALUE = '0
) (
	input  logic                BASECK,
	input  logic                SYSRSOUTB,
	input  logic                wr_en,
	input  bfbrk_pkg::slot_idx_t wr_idx,
	input  payload_t            wr_value,
	output payload_t            entries [N_SLOTS]
);

	logic [N_SLOTS-1:0] load;   // One write enable per entry

	// Index decode
	always_comb begin
		for (int i = 0; i < N_SLOTS; i++) begin
			load[i] = wr_en && (wr_idx == i);
		end
	end

	// --------------------
	// Slot registers
	// --------------------
	for (genvar g = 0; g < N_SLOTS; g++) begin : g_slot
		always_ff @(posedge BASECK or negedge SYSRSOUTB) begin
			if (!SYSRSOUTB) begin
				entries[g] <= RESET_VALUE;
			end else if (load[g]) begin
				entries[g] <= wr_value;   // Visible from the write edge on
			end
		end
	end

endmodule

/* hw/bfbrk_top.sv */
// N_SLOTS from 1 to 8; host writes reach the patch outputs one BASECK after the write edge

`timescale 1ns/1ps

module bfbrk_top #(
	parameter int N_SLOTS = bfbrk_pkg::SLOT_MAX
) (
	input  logic                  BASECK,
	input  logic                  SYSRSOUTB,
	input  bfbrk_pkg::host_req_t  host,
	input  bfbrk_pkg::fetch_t     fetch,
	output bfbrk_pkg::host_word_t rdata,
	output bfbrk_pkg::patch_t     patch
);

	import bfbrk_pkg::*;

	// Bank write side
	logic        addr_wr_en;
	logic        data_wr_en;
	slot_idx_t   wr_idx;
	fetch_addr_t addr_wr_value;
	patch_word_t data_wr_value;

	// Register contents
	fetch_addr_t        addr_entries [N_SLOTS];
	patch_word_t        data_entries [N_SLOTS];
	logic [N_SLOTS-1:0] enables;

	bfbrk_host_regs #(.N_SLOTS(N_SLOTS)) host_regs (
		.BASECK        (BASECK),
		.SYSRSOUTB     (SYSRSOUTB),
		.host          (host),
		.addr_entries  (addr_entries),
		.data_entries  (data_entries),
		.addr_wr_en    (addr_wr_en),
		.data_wr_en    (data_wr_en),
		.wr_idx        (wr_idx),
		.addr_wr_value (addr_wr_value),
		.data_wr_value (data_wr_value),
		.enables       (enables),
		.rdata         (rdata)
	);

	// --------------------
	// Slot banks
	// --------------------
	bfbrk_slot_bank #(
		.N_SLOTS     (N_SLOTS),
		.payload_t   (fetch_addr_t),
		.RESET_VALUE (ADDR_RESET)
	) addr_bank (
		.BASECK   (BASECK),
		.SYSRSOUTB(SYSRSOUTB),
		.wr_en    (addr_wr_en),
		.wr_idx   (wr_idx),
		.wr_value (addr_wr_value),
		.entries  (addr_entries)
	);

	bfbrk_slot_bank #(
		.N_SLOTS     (N_SLOTS),
		.payload_t   (patch_word_t),
		.RESET_VALUE ('0)
	) data_bank (
		.BASECK   (BASECK),
		.SYSRSOUTB(SYSRSOUTB),
		.wr_en    (data_wr_en),
		.wr_idx   (wr_idx),
		.wr_value (data_wr_value),
		.entries  (data_entries)
	);

	bfbrk_match #(.N_SLOTS(N_SLOTS)) match (
		.BASECK       (BASECK),
		.SYSRSOUTB    (SYSRSOUTB),
		.fetch        (fetch),
		.addr_entries (addr_entries),
		.data_entries (data_entries),
		.enables      (enables),
		.patch        (patch)
	);

endmodule

/* verification/bfbrk_sva.sv */
// Bound to every bfbrk_top instance; properties are sampled on the rising BASECK edge only

`timescale 1ns/1ps

module bfbrk_sva (
	input logic              BASECK,
	input logic              SYSRSOUTB,
	input bfbrk_pkg::fetch_t fetch,
	input bfbrk_pkg::patch_t patch
);

	int fails = 0;    // Failed assertion count

	// --------------------
	// Reset release
	// --------------------
	property sel_low_after_reset;
		@(posedge BASECK) $rose(SYSRSOUTB) |=> !patch.sel;
	endproperty

	a_sel_low_after_reset: assert property (sel_low_after_reset)
		else begin
			fails++;
			$error("patch.sel high in the first cycle after reset release");
		end

	// --------------------
	// Suppression
	// --------------------
	property no_sel_after_svmod;
		@(posedge BASECK) disable iff (!SYSRSOUTB)
			fetch.svmodf |=> !patch.sel;    // Supervisor fetches never patched
	endproperty

	property no_sel_after_waited_read;
		@(posedge BASECK) disable iff (!SYSRSOUTB)
			(fetch.flread && fetch.pcwaitf) |=> !patch.sel;
	endproperty

	a_no_sel_after_svmod: assert property (no_sel_after_svmod)
		else begin
			fails++;
			$error("patch.sel high after a supervisor fetch");
		end

	a_no_sel_after_waited_read: assert property (no_sel_after_waited_read)
		else begin
			fails++;
			$error("patch.sel high after a waited flash read");
		end

endmodule

bind bfbrk_top bfbrk_sva sva0 (
	.BASECK    (BASECK),
	.SYSRSOUTB (SYSRSOUTB),
	.fetch     (fetch),
	.patch     (patch)
);

/* verification/tb_bfbrk.sv */
// Runs bfbrk_top with N_SLOTS of 8; no host writes are made while a fetch result is pending

`timescale 1ns/1ps

module tb_bfbrk;

	import bfbrk_pkg::*;

	localparam int N = 8;
	localparam int DRAIN_LIMIT = 20;    // Cycles allowed for pending results to be checked

	logic       BASECK;
	logic       SYSRSOUTB;
	host_req_t  host;
	fetch_t     fetch;
	host_word_t rdata;
	patch_t     patch;

	// Model of the unit's registers
	fetch_addr_t  m_addr [N];
	patch_word_t  m_data [N];
	logic [N-1:0] m_en;

	patch_t exp_q [$];    // One expected result per applied fetch
	patch_t armed;
	bit     armed_valid;
	int     errors;
	int     checks;
	int     tests;
	int     tests_failed;
	int     test_err_start;

	bfbrk_top #(.N_SLOTS(N)) dut0 (
		.BASECK    (BASECK),
		.SYSRSOUTB (SYSRSOUTB),
		.host      (host),
		.fetch     (fetch),
		.rdata     (rdata),
		.patch     (patch)
	);

	initial begin
		BASECK = 1'b0;
		forever #5 BASECK = ~BASECK;
	end

	// --------------------
	// Checks
	// --------------------
	task automatic check_patch(patch_t exp, patch_t act, string name);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected sel=%b data=%h, got sel=%b data=%h",
				$time, name, exp.sel, exp.data, act.sel, act.data);
		end
	endtask

	task automatic check_word(host_word_t exp, host_word_t act, string name);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// --------------------
	// Model and reference
	// --------------------
	function automatic host_word_t slot_addr(int i);
		return {HOST_BASE, 8'(int'(ADDR_OFS) + 4 * i)};
	endfunction

	function automatic host_word_t data_addr(int i);
		return {HOST_BASE, 8'(int'(DATA_OFS) + 4 * i)};
	endfunction

	function automatic host_word_t byte_addr(fetch_addr_t a);
		return {12'h000, a, 2'b00};    // Word address back in byte form
	endfunction

	// 0 none, 1 address slot, 2 data slot, 3 enable register
	function automatic int reg_kind(host_word_t a);
		int ofs;
		ofs = a[7:0];
		if (a[31:8] != HOST_BASE || ofs % 4 != 0) begin
			return 0;
		end
		if (ofs >= int'(ADDR_OFS) && ofs < int'(ADDR_OFS) + 4 * N) begin
			return 1;
		end
		if (ofs >= int'(DATA_OFS) && ofs < int'(DATA_OFS) + 4 * N) begin
			return 2;
		end
		return (ofs == int'(CTRL_OFS)) ? 3 : 0;
	endfunction

	function automatic host_word_t exp_rdata(host_word_t a);
		host_word_t r;
		int         idx;
		r = '0;
		idx = (a[7:0] / 4) % N;
		case (reg_kind(a))
			1: r[19:2] = m_addr[idx];
			2: r = m_data[idx];
			3: r[N-1:0] = m_en;
			default: r = '0;
		endcase
		return r;
	endfunction

	// Lowest enabled match wins; suppression only clears sel
	function automatic patch_t ref_patch(fetch_t f);
		patch_t p;
		bit     hit;
		p = '0;
		hit = 1'b0;
		for (int i = 0; i < N; i++) begin
			if (!hit && m_en[i] && m_addr[i] == f.pa) begin
				hit = 1'b1;
				p.data = m_data[i];
			end
		end
		p.sel = hit && !f.svmodf && !(f.flread && f.pcwaitf);
		return p;
	endfunction

	function automatic fetch_t make_fetch(fetch_addr_t pa, logic fl, logic pw, logic sv);
		return '{pa: pa, flread: fl, pcwaitf: pw, svmodf: sv};
	endfunction

	// --------------------
	// Stimulus tasks
	// --------------------
	task automatic host_write(host_word_t a, host_word_t d);
		int idx;
		idx = (a[7:0] / 4) % N;
		@(posedge BASECK);
		host <= '{wr: 1'b1, addr: a, wdata: d};
		@(posedge BASECK);
		host.wr <= 1'b0;    // Register took the value at this edge
		case (reg_kind(a))
			1: m_addr[idx] = d[19:2];
			2: m_data[idx] = d;
			3: m_en = d[N-1:0];
			default: ;
		endcase
	endtask

	task automatic host_read(host_word_t a);
		@(posedge BASECK);
		host <= '{wr: 1'b0, addr: a, wdata: $urandom};
		@(negedge BASECK);
		check_word(exp_rdata(a), rdata, $sformatf("rdata[%h]", a));
	endtask

	task automatic read_all();
		for (int i = 0; i < N; i++) begin
			host_read(slot_addr(i));
			host_read(data_addr(i));
		end
		host_read({HOST_BASE, CTRL_OFS});
		host_read({HOST_BASE, 8'h44});
		host_read(32'h0840_3100);     // Next window up
	endtask

	task automatic apply_fetch(fetch_t f);
		@(posedge BASECK);
		fetch <= f;
		exp_q.push_back(ref_patch(f));
	endtask

	task automatic drain_checks();
		int n;
		n = 0;
		while ((exp_q.size() > 0 || armed_valid) && n < DRAIN_LIMIT) begin
			@(posedge BASECK);
			n++;
		end
		if (exp_q.size() > 0 || armed_valid) begin
			$display("Timeout: patch results still pending after %0d cycles", DRAIN_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	endtask

	task automatic end_test(string name);
		int n_err;
		drain_checks();
		n_err = errors + dut0.sva0.fails;    // Bound assertion failures count too
		tests++;
		if (n_err > test_err_start) begin
			tests_failed++;
			$display("test %0d %s: failed, %0d errors", tests, name, n_err - test_err_start);
		end else begin
			$display("test %0d %s: passed", tests, name);
		end
		test_err_start = n_err;
	endtask

	// Patch is compared one edge after its fetch was driven
	initial begin
		armed_valid = 1'b0;
		forever begin
			@(negedge BASECK);
			if (armed_valid) begin
				check_patch(armed, patch, "patch");
			end
			armed_valid = (exp_q.size() > 0);
			if (armed_valid) begin
				armed = exp_q.pop_front();
			end
		end
	end

	// --------------------
	// Test sequence
	// --------------------
	initial begin
		fetch_addr_t a;
		void'($urandom(32'h4a7f_f0f2));
		SYSRSOUTB = 1'b0;
		host = '0;
		fetch = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		tests_failed = 0;
		test_err_start = 0;
		m_en = '0;
		for (int i = 0; i < N; i++) begin
			m_addr[i] = '1;
			m_data[i] = '0;
		end
		repeat (2) @(posedge BASECK);
		SYSRSOUTB <= 1'b1;

		read_all();
		end_test("reset read-back");

		for (int i = 0; i < N; i++) begin
			host_write(slot_addr(i), $urandom | 32'hfff0_0003);   // Bits outside 19:2 set
			host_write(data_addr(i), $urandom);
		end
		host_write({HOST_BASE, CTRL_OFS}, $urandom);
		host_write({HOST_BASE, 8'h44}, 32'hffff_ffff);          // Unmapped offset
		read_all();
		end_test("write and read-back");

		a = 18'h0_1234;
		host_write(slot_addr(2), byte_addr(a));
		host_write(data_addr(2), 32'hcafe_0002);
		host_write({HOST_BASE, CTRL_OFS}, 32'h04);
		apply_fetch(make_fetch(a, 1'b0, 1'b0, 1'b0));
		host_write({HOST_BASE, CTRL_OFS}, 32'h00);
		apply_fetch(make_fetch(a, 1'b0, 1'b0, 1'b0));
		end_test("enabled match");

		a = 18'h2_a5a0;
		host_write(slot_addr(1), byte_addr(a));
		host_write(slot_addr(5), byte_addr(a));
		host_write(data_addr(1), 32'h1111_0001);
		host_write(data_addr(5), 32'h5555_0005);
		host_write({HOST_BASE, CTRL_OFS}, 32'h22);
		apply_fetch(make_fetch(a, 1'b0, 1'b0, 1'b0));
		host_write({HOST_BASE, CTRL_OFS}, 32'h20);
		apply_fetch(make_fetch(a, 1'b0, 1'b0, 1'b0));
		end_test("priority");

		a = 18'h0_0f0c;
		host_write(slot_addr(3), byte_addr(a));
		host_write(data_addr(3), 32'h3333_0003);
		host_write({HOST_BASE, CTRL_OFS}, 32'h08);
		apply_fetch(make_fetch(a, 1'b0, 1'b0, 1'b1));   // Supervisor fetch
		apply_fetch(make_fetch(a, 1'b1, 1'b1, 1'b0));   // Waited read
		apply_fetch(make_fetch(a, 1'b1, 1'b0, 1'b0));
		apply_fetch(make_fetch(a, 1'b0, 1'b1, 1'b0));
		end_test("suppression");

		// Small address pool so that slots overlap
		for (int i = 0; i < N; i++) begin
			host_write(slot_addr(i), byte_addr(18'h0_0100 + 18'($urandom % 16)));
			host_write(data_addr(i), $urandom);
		end
		host_write({HOST_BASE, CTRL_OFS}, $urandom | 32'h11);
		for (int k = 0; k < 200; k++) begin
			if ($urandom % 2) begin
				a = m_addr[$urandom % N];
			end else begin
				a = 18'h0_0100 + 18'($urandom % 64);
			end
			apply_fetch(make_fetch(a, 1'($urandom % 2), 1'($urandom % 4 == 0),
				1'($urandom % 8 == 0)));
		end
		end_test("random stream");

		$display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests, tests_failed, checks, errors, dut0.sva0.fails);
		if (errors == 0 && dut0.sva0.fails == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
